/* project.f */
sys_pkg.sv
csr_key_mux.sv
csr_file.sv
sys_ctrl.sv
sys_unit.sv
tb_clkgen.sv
sys_unit_tb.sv

/* Bender.yml */
package:
  name: sys_unit

sources:
  - sys_pkg.sv
  - csr_key_mux.sv
  - csr_file.sv
  - sys_ctrl.sv
  - sys_unit.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - sys_unit_tb.sv

/* sys_unit_tb.sv */
// self-checking testbench for sys_unit at XLEN 64; a model mirrors the four CSRs.
`timescale 1ns/1ns
`default_nettype none

module sys_unit_tb;

  localparam int XLEN         = 64;
  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 5;
  localparam int RW_ROUNDS    = 4;
  localparam int SC_ROUNDS    = 3;
  localparam int TRAP_ROUNDS  = 3;
  localparam int INSTR_COUNT  = 4 + RW_ROUNDS * 8 + 8 + SC_ROUNDS * 20 + TRAP_ROUNDS * 9 + 16;
  localparam int WATCHDOG_NS  = (INSTR_COUNT + RESET_CYCLES) * PERIOD * 2 + 10 * PERIOD;

  localparam logic [6:0]  OPC_SYSTEM   = 7'b1110011;
  localparam logic [2:0]  F3_CSRRW     = 3'b001;
  localparam logic [2:0]  F3_CSRRS     = 3'b010;
  localparam logic [2:0]  F3_CSRRC     = 3'b011;
  localparam logic [31:0] ECALL_WORD   = 32'h0000_0073;
  localparam logic [31:0] MRET_WORD    = 32'h3020_0073;
  localparam logic [63:0] MSTATUS_INIT = 64'h0000_000a_0000_1800;

  logic            clk;
  logic            reset;
  logic            valid;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rs1_data;
  logic            rd_wen;
  logic [4:0]      rd_addr;
  logic [XLEN-1:0] rd_data;
  logic            change_pc;
  logic [XLEN-1:0] nextpc;

  logic [63:0] model_mstatus;
  logic [63:0] model_mtvec;
  logic [63:0] model_mepc;
  logic [63:0] model_mcause;

  int     errors = 0;
  int     checks = 0;
  integer seed   = 32'h2c1f_98a0;

  tb_clkgen #(
    .PERIOD       (PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) clkgen_i (
    .o_clk   (clk),
    .o_reset (reset)
  );

  sys_unit #(
    .XLEN (XLEN)
  ) dut_i (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_valid     (valid),
    .i_inst      (inst),
    .i_pc        (pc),
    .i_rs1_data  (rs1_data),
    .o_rd_wen    (rd_wen),
    .o_rd_addr   (rd_addr),
    .o_rd_data   (rd_data),
    .o_change_pc (change_pc),
    .o_nextpc    (nextpc)
  );

  function automatic logic [11:0] addr_of(input int idx);
    case (idx)
      0: return 12'h300;
      1: return 12'h305;
      2: return 12'h341;
      default: return 12'h342;
    endcase
  endfunction

  function automatic logic [63:0] model_read(input logic [11:0] addr);
    case (addr)
      12'h300: return model_mstatus;
      12'h305: return model_mtvec;
      12'h341: return model_mepc;
      12'h342: return model_mcause;
      default: return 64'd0;
    endcase
  endfunction

  // unknown addresses are dropped.
  task automatic model_write(input logic [11:0] addr, input logic [63:0] value);
    case (addr)
      12'h300: model_mstatus = value;
      12'h305: model_mtvec = value;
      12'h341: model_mepc = value;
      12'h342: model_mcause = value;
      default: begin
      end
    endcase
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [31:0] csr_inst(input logic [2:0] f3, input logic [11:0] csr,
                                           input logic [4:0] rs1, input logic [4:0] rd);
    return {csr, rs1, f3, rd, OPC_SYSTEM};
  endfunction

  task automatic check_value(input string name, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Error: test %s, %s expected %h, actual %h", name, field, exp, act);
    end
  endtask

  // drive on the rising edge, check at the falling edge, then advance the model.
  task automatic run_inst(input string name, input logic v, input logic [31:0] word,
                          input logic [63:0] at_pc, input logic [63:0] rs1_val);
    logic        is_sys;
    logic        is_csr;
    logic        is_ecall;
    logic        is_mret;
    logic        exp_wen;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [11:0] f12;
    logic [63:0] old;
    logic [63:0] exp_pc;
    @(posedge clk);
    valid    <= v;
    inst     <= word;
    pc       <= at_pc;
    rs1_data <= rs1_val;
    @(negedge clk);
    rd       = word[11:7];
    f3       = word[14:12];
    rs1      = word[19:15];
    f12      = word[31:20];
    is_sys   = v && (word[6:0] == OPC_SYSTEM);
    is_csr   = is_sys && (f3 == F3_CSRRW || f3 == F3_CSRRS || f3 == F3_CSRRC);
    is_ecall = is_sys && f3 == 3'b000 && f12 == 12'h000;
    is_mret  = is_sys && f3 == 3'b000 && f12 == 12'h302;
    old      = model_read(f12);
    exp_wen  = is_csr && rd != 5'd0;
    exp_pc   = is_ecall ? model_mtvec : (is_mret ? model_mepc : 64'd0);
    check_value(name, "rd_wen", exp_wen, rd_wen);
    if (exp_wen) begin
      check_value(name, "rd_addr", rd, rd_addr);
      check_value(name, "rd_data", old, rd_data);
    end
    check_value(name, "change_pc", is_ecall || is_mret, change_pc);
    check_value(name, "nextpc", exp_pc, nextpc);
    if (is_ecall) begin
      model_mepc   = at_pc;
      model_mcause = 64'd11;
    end else if (is_mret) begin
      model_mstatus = MSTATUS_INIT;
    end else if (is_csr) begin
      if (f3 == F3_CSRRW) begin
        model_write(f12, rs1_val);
      end else if (f3 == F3_CSRRS && rs1 != 5'd0) begin
        model_write(f12, old | rs1_val);
      end else if (f3 == F3_CSRRC && rs1 != 5'd0) begin
        model_write(f12, old & ~rs1_val);
      end
    end
  endtask

  // rs1 field is x0, the data bus still carries noise.
  task automatic read_csr(input string name, input logic [11:0] addr);
    run_inst(name, 1'b1, csr_inst(F3_CSRRS, addr, 5'd0, 5'd5), rand64() & ~64'h3, rand64());
  endtask

  task automatic test_read_write();
    for (int r = 0; r < RW_ROUNDS; r++) begin
      for (int i = 0; i < 4; i++) begin
        run_inst("read_write", 1'b1, csr_inst(F3_CSRRW, addr_of(i), 5'd2, 5'd1), 64'd0, rand64());
        read_csr("read_write", addr_of(i));
      end
    end
    for (int i = 0; i < 4; i++) begin
      run_inst("write_x0", 1'b1, csr_inst(F3_CSRRW, addr_of(i), 5'd2, 5'd0), 64'd0, rand64());
      read_csr("write_x0", addr_of(i));
    end
  endtask

  task automatic test_set_clear();
    for (int r = 0; r < SC_ROUNDS; r++) begin
      for (int i = 0; i < 4; i++) begin
        run_inst("set_bits", 1'b1, csr_inst(F3_CSRRS, addr_of(i), 5'd6, 5'd4), 64'd0, rand64());
        run_inst("clear_bits", 1'b1, csr_inst(F3_CSRRC, addr_of(i), 5'd7, 5'd4), 64'd0, rand64());
        run_inst("set_x0", 1'b1, csr_inst(F3_CSRRS, addr_of(i), 5'd0, 5'd4), 64'd0, rand64());
        run_inst("clear_x0", 1'b1, csr_inst(F3_CSRRC, addr_of(i), 5'd0, 5'd4), 64'd0, rand64());
        read_csr("set_clear", addr_of(i));
      end
    end
  endtask

  task automatic test_traps();
    for (int r = 0; r < TRAP_ROUNDS; r++) begin
      run_inst("trap_entry", 1'b1, csr_inst(F3_CSRRW, 12'h305, 5'd3, 5'd0), 64'd0, rand64());
      run_inst("trap_entry", 1'b1, ECALL_WORD, rand64() & ~64'h3, rand64());
      read_csr("trap_entry", 12'h341);
      read_csr("trap_entry", 12'h342);
    end
    for (int r = 0; r < TRAP_ROUNDS; r++) begin
      run_inst("trap_return", 1'b1, csr_inst(F3_CSRRW, 12'h300, 5'd3, 5'd0), 64'd0, rand64());
      run_inst("trap_return", 1'b1, csr_inst(F3_CSRRW, 12'h341, 5'd3, 5'd0), 64'd0, rand64());
      run_inst("trap_return", 1'b1, MRET_WORD, rand64() & ~64'h3, rand64());
      read_csr("trap_return", 12'h300);
      read_csr("trap_return", 12'h341);
    end
  endtask

  task automatic test_idle_unknown();
    read_csr("unknown_csr", 12'h301);
    read_csr("unknown_csr", 12'h7c0);
    run_inst("unknown_csr", 1'b1, csr_inst(F3_CSRRW, 12'h301, 5'd2, 5'd1), 64'd0, rand64());
    run_inst("unknown_csr", 1'b1, csr_inst(F3_CSRRW, 12'h7c0, 5'd2, 5'd1), 64'd0, rand64());
    for (int i = 0; i < 4; i++) begin
      read_csr("unknown_csr", addr_of(i));
    end
    run_inst("idle", 1'b0, csr_inst(F3_CSRRW, 12'h305, 5'd2, 5'd1), 64'd0, rand64());
    run_inst("idle", 1'b0, ECALL_WORD, rand64() & ~64'h3, rand64());
    run_inst("idle", 1'b0, MRET_WORD, rand64() & ~64'h3, rand64());
    // addi x1, x0, 5 is not a system instruction.
    run_inst("idle", 1'b1, 32'h0050_0093, 64'd0, rand64());
    for (int i = 0; i < 4; i++) begin
      read_csr("idle", addr_of(i));
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    model_mstatus = MSTATUS_INIT;
    model_mtvec   = 64'd0;
    model_mepc    = 64'd0;
    model_mcause  = 64'd0;
    valid    <= 1'b1;
    inst     <= MRET_WORD;
    pc       <= '0;
    rs1_data <= '0;
    // a csr write and an mret held during reset must not leak out.
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      @(posedge clk);
      inst <= i[0] ? MRET_WORD : csr_inst(F3_CSRRW, 12'h305, 5'd2, 5'd1);
      @(negedge clk);
      if (reset) begin
        check_value("reset_gate", "change_pc", 64'd0, change_pc);
        check_value("reset_gate", "rd_wen", 64'd0, rd_wen);
      end
    end
    @(posedge clk);
    valid <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      read_csr("reset_values", addr_of(i));
    end
    test_read_write();
    test_set_clear();
    test_traps();
    test_idle_unknown();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// testbench clock and reset; reset is released on a rising edge after RESET_CYCLES edges.
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_reset
);

  initial o_clk = 1'b0;

  always #(PERIOD / 2) o_clk = ~o_clk;

  // synchronous reset, dropped on a rising edge.
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* sys_unit.sv */
// system unit top; one instruction per cycle, combinational results, no stall.
`timescale 1ns/1ns
`default_nettype none

module sys_unit #(
  parameter int XLEN = sys_pkg::XLEN_DEFAULT
) (
  input  wire logic            i_clk,
  input  wire logic            i_reset,
  input  wire logic            i_valid,
  input  wire logic [31:0]     i_inst,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic [XLEN-1:0] i_rs1_data,
  output logic                 o_rd_wen,
  output logic      [4:0]      o_rd_addr,
  output logic      [XLEN-1:0] o_rd_data,
  output logic                 o_change_pc,
  output logic      [XLEN-1:0] o_nextpc
);

  import sys_pkg::*;

  sys_op_e               op;
  logic [CSR_ADDR_W-1:0] csr_addr;
  logic                  csr_wen;
  logic [XLEN-1:0]       csr_wdata;
  logic [XLEN-1:0]       csr_rdata;

  sys_ctrl #(
    .XLEN (XLEN)
  ) u_ctrl (
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_inst      (i_inst),
    .i_rs1_data  (i_rs1_data),
    .i_csr_rdata (csr_rdata),
    .o_op        (op),
    .o_csr_addr  (csr_addr),
    .o_csr_wen   (csr_wen),
    .o_csr_wdata (csr_wdata),
    .o_rd_wen    (o_rd_wen),
    .o_rd_addr   (o_rd_addr),
    .o_rd_data   (o_rd_data)
  );

  // the instruction pc becomes mepc on ecall.
  csr_file #(
    .XLEN (XLEN)
  ) u_csr (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_op        (op),
    .i_addr      (csr_addr),
    .i_wen       (csr_wen),
    .i_wdata     (csr_wdata),
    .i_epc       (i_pc),
    .o_rdata     (csr_rdata),
    .o_nextpc    (o_nextpc),
    .o_change_pc (o_change_pc)
  );

endmodule

`default_nettype wire

/* sys_ctrl.sv */
// SYSTEM decode for csrrw/csrrs/csrrc/ecall/mret; immediate CSR forms decode as no operation.
`timescale 1ns/1ns
`default_nettype none

module sys_ctrl #(
  parameter int XLEN = sys_pkg::XLEN_DEFAULT
) (
  input  wire logic                          i_reset,
  input  wire logic                          i_valid,
  input  wire logic [31:0]                   i_inst,
  input  wire logic [XLEN-1:0]               i_rs1_data,
  input  wire logic [XLEN-1:0]               i_csr_rdata,
  output sys_pkg::sys_op_e                   o_op,
  output logic      [sys_pkg::CSR_ADDR_W-1:0] o_csr_addr,
  output logic                               o_csr_wen,
  output logic      [XLEN-1:0]               o_csr_wdata,
  output logic                               o_rd_wen,
  output logic      [4:0]                    o_rd_addr,
  output logic      [XLEN-1:0]               o_rd_data
);

  import sys_pkg::*;

  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [4:0]  rs1;
  logic [11:0] funct12;
  logic        active;
  logic        is_csr_op;

  assign opcode  = i_inst[6:0];
  assign rd      = i_inst[11:7];
  assign funct3  = i_inst[14:12];
  assign rs1     = i_inst[19:15];
  assign funct12 = i_inst[31:20];

  // nothing leaves the unit during reset.
  assign active = i_valid & ~i_reset;

  always_comb begin
    o_op = SYS_NONE;
    if (active && opcode == OPC_SYSTEM) begin
      case (funct3)
        FUNCT3_CSRRW: begin
          o_op = SYS_CSRRW;
        end
        FUNCT3_CSRRS: begin
          o_op = SYS_CSRRS;
        end
        FUNCT3_CSRRC: begin
          o_op = SYS_CSRRC;
        end
        FUNCT3_PRIV: begin
          if (funct12 == IMM_ECALL) begin
            o_op = SYS_ECALL;
          end else if (funct12 == IMM_MRET) begin
            o_op = SYS_MRET;
          end
        end
        default: begin
          o_op = SYS_NONE;
        end
      endcase
    end
  end

  assign is_csr_op = (o_op == SYS_CSRRW) || (o_op == SYS_CSRRS) || (o_op == SYS_CSRRC);

  // csr address sits in the funct12 field.
  assign o_csr_addr = funct12;

  // write value and enable; set/clear with x0 leave the CSR alone.
  always_comb begin
    o_csr_wdata = '0;
    o_csr_wen   = 1'b0;
    case (o_op)
      SYS_CSRRW: begin
        o_csr_wdata = i_rs1_data;
        o_csr_wen   = 1'b1;
      end
      SYS_CSRRS: begin
        o_csr_wdata = i_csr_rdata | i_rs1_data;
        o_csr_wen   = (rs1 != 5'd0);
      end
      SYS_CSRRC: begin
        o_csr_wdata = i_csr_rdata & ~i_rs1_data;
        o_csr_wen   = (rs1 != 5'd0);
      end
      default: begin
        o_csr_wdata = '0;
        o_csr_wen   = 1'b0;
      end
    endcase
  end

  // old csr value goes to rd, x0 is never written.
  assign o_rd_wen  = is_csr_op && (rd != 5'd0);
  assign o_rd_addr = o_rd_wen ? rd : 5'd0;
  assign o_rd_data = o_rd_wen ? i_csr_rdata : '0;

endmodule

`default_nettype wire

/* csr_file.sv */
// four machine CSRs; unknown addresses read zero, trap updates win over a CSR write.
`timescale 1ns/1ns
`default_nettype none

module csr_file #(
  parameter int XLEN = sys_pkg::XLEN_DEFAULT
) (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset,
  input  wire sys_pkg::sys_op_e              i_op,
  input  wire logic [sys_pkg::CSR_ADDR_W-1:0] i_addr,
  input  wire logic                          i_wen,
  input  wire logic [XLEN-1:0]               i_wdata,
  input  wire logic [XLEN-1:0]               i_epc,
  output logic      [XLEN-1:0]               o_rdata,
  output logic      [XLEN-1:0]               o_nextpc,
  output logic                               o_change_pc
);

  import sys_pkg::*;

  localparam int LUT_W = NR_CSR * (CSR_ADDR_W + XLEN);

  logic [XLEN-1:0]  mstatus;
  logic [XLEN-1:0]  mtvec;
  logic [XLEN-1:0]  mepc;
  logic [XLEN-1:0]  mcause;
  logic [LUT_W-1:0] csr_lut;
  logic             addr_hit;
  logic             csr_write;

  assign csr_lut = {
    CSR_MSTATUS, mstatus,
    CSR_MTVEC,   mtvec,
    CSR_MEPC,    mepc,
    CSR_MCAUSE,  mcause
  };

  // read and write share the same address.
  csr_key_mux #(
    .NR_KEY   (NR_CSR),
    .KEY_LEN  (CSR_ADDR_W),
    .DATA_LEN (XLEN)
  ) u_key_mux (
    .i_key  (i_addr),
    .i_lut  (csr_lut),
    .o_data (o_rdata),
    .o_hit  (addr_hit)
  );

  // writes to unknown addresses are dropped.
  assign csr_write = i_wen & addr_hit;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= XLEN'(MSTATUS_RESET);
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_op == SYS_ECALL) begin
      mepc   <= i_epc;
      mcause <= XLEN'(CAUSE_ECALL_M);
    end else if (i_op == SYS_MRET) begin
      // no interrupt-enable stacking, just restore.
      mstatus <= XLEN'(MSTATUS_RESET);
    end else if (csr_write) begin
      case (i_addr)
        CSR_MSTATUS: begin
          mstatus <= i_wdata;
        end
        CSR_MTVEC: begin
          mtvec <= i_wdata;
        end
        CSR_MEPC: begin
          mepc <= i_wdata;
        end
        CSR_MCAUSE: begin
          mcause <= i_wdata;
        end
        default: begin
        end
      endcase
    end
  end

  // pc redirect on trap entry and return.
  always_comb begin
    o_nextpc    = '0;
    o_change_pc = 1'b0;
    case (i_op)
      SYS_ECALL: begin
        o_nextpc    = mtvec;
        o_change_pc = 1'b1;
      end
      SYS_MRET: begin
        o_nextpc    = mepc;
        o_change_pc = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* csr_key_mux.sv */
// key/value lookup; keys should be unique, a miss returns zero with o_hit low.
`timescale 1ns/1ns
`default_nettype none

module csr_key_mux #(
  parameter int NR_KEY   = 4,
  parameter int KEY_LEN  = 12,
  parameter int DATA_LEN = 64
) (
  input  wire logic [KEY_LEN-1:0]                  i_key,
  input  wire logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] i_lut,
  output logic      [DATA_LEN-1:0]                 o_data,
  output logic                                     o_hit
);

  localparam int ENTRY_W = KEY_LEN + DATA_LEN;

  // each entry holds the key above its data.
  always_comb begin
    logic [ENTRY_W-1:0] entry;
    entry  = '0;
    o_data = '0;
    o_hit  = 1'b0;
    for (int i = 0; i < NR_KEY; i++) begin
      entry = i_lut[i*ENTRY_W +: ENTRY_W];
      if (entry[ENTRY_W-1 -: KEY_LEN] == i_key) begin
        o_data = o_data | entry[DATA_LEN-1:0];
        o_hit  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* sys_pkg.sv */
// machine-mode system definitions; only four CSRs exist and MSTATUS_RESET is 64 bits wide.
`default_nettype none

package sys_pkg;

  // widths.
  localparam int CSR_ADDR_W   = 12;
  localparam int XLEN_DEFAULT = 64;

  // implemented CSR addresses.
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

  localparam int NR_CSR = 4;

  // mstatus after reset and after mret, MPP set to M.
  localparam logic [63:0] MSTATUS_RESET = 64'h0000_000a_0000_1800;

  // environment call from M-mode.
  localparam logic [63:0] CAUSE_ECALL_M = 64'd11;

  // instruction fields.
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
  localparam logic [2:0] FUNCT3_PRIV  = 3'b000;
  localparam logic [2:0] FUNCT3_CSRRW = 3'b001;
  localparam logic [2:0] FUNCT3_CSRRS = 3'b010;
  localparam logic [2:0] FUNCT3_CSRRC = 3'b011;

  // funct12 of the privileged instructions.
  localparam logic [11:0] IMM_ECALL = 12'h000;
  localparam logic [11:0] IMM_MRET  = 12'h302;

  // system operation seen by the CSR file.
  typedef enum logic [2:0] {
    SYS_NONE  = 3'd0,
    SYS_CSRRW = 3'd1,
    SYS_CSRRS = 3'd2,
    SYS_CSRRC = 3'd3,
    SYS_ECALL = 3'd4,
    SYS_MRET  = 3'd5
  } sys_op_e;

endpackage

`default_nettype wire
